//--- project.f
hw/fetch_pkg.sv
hw/pair_classify.sv
hw/inst_queue.sv
hw/fetch_ctrl.sv
hw/fetch_stage.sv
test/tb_clock.sv
test/fetch_stage_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch_stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module fetch_stage_tb \
    -Mdir obj_dir -o sim_fetch_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_fetch_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '** PASS **'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- test/fetch_stage_tb.sv
`timescale 1ns/1ns

module fetch_stage_tb;

    localparam int xlen       = fetch_pkg::XLEN;
    localparam int line_words = fetch_pkg::LINE_WORDS_DEFAULT;
    localparam int cnt_w      = $clog2(line_words + 1);
    localparam int step_w     = cnt_w + 2;
    localparam int max_wait   = 200;

    // controller states as seen by the model
    localparam int st_wait    = 0;
    localparam int st_recv    = 1;
    localparam int st_discard = 2;

    logic                       clk;
    logic                       reset;
    logic                       to_fs_valid;
    logic [xlen-1:0]            fetch_pc;
    logic                       fs_allowin;
    logic [step_w-1:0]          pc_step;
    logic                       line_ok;
    logic [cnt_w-1:0]           line_count;
    logic [line_words*xlen-1:0] line_data;
    logic                       ds_allowin;
    logic                       fs_to_ds_valid;
    logic [xlen-1:0]            inst1_pc;
    logic [xlen-1:0]            inst1_word;
    logic [xlen-1:0]            inst2_pc;
    logic [xlen-1:0]            inst2_word;
    logic                       inst2_valid;
    logic                       flush;

    int seed = 32'h7d2e5e03;
    int errors = 0;
    int timeouts = 0;
    int pairs = 0;
    int singles = 0;
    int lines = 0;
    int flushes = 0;

    // queue model, one word and one pc per entry
    logic [xlen-1:0] model_word [$];
    logic [xlen-1:0] model_pc [$];

    int                ctrl_state = st_wait;
    logic [xlen-1:0]   req_pc = '0;
    logic [xlen-1:0]   next_fetch_pc = 32'hbfc0_0000;
    logic [step_w-1:0] exp_step = step_w'(4);
    logic              reply_due = 1'b0;
    int                reply_delay = 0;
    logic              held = 1'b0;
    logic [xlen-1:0]   held_pc = '0;
    logic [xlen-1:0]   held_word = '0;

    tb_clock #(
        .period      (20),
        .reset_cycles(16)
    ) clock_gen (
        .clk  (clk),
        .reset(reset)
    );

    fetch_stage #(
        .line_words (line_words),
        .queue_depth(fetch_pkg::QUEUE_DEPTH_DEFAULT)
    ) DUT (
        .clk           (clk),
        .reset         (reset),
        .to_fs_valid   (to_fs_valid),
        .fetch_pc      (fetch_pc),
        .fs_allowin    (fs_allowin),
        .pc_step       (pc_step),
        .line_ok       (line_ok),
        .line_count    (line_count),
        .line_data     (line_data),
        .ds_allowin    (ds_allowin),
        .fs_to_ds_valid(fs_to_ds_valid),
        .inst1_pc      (inst1_pc),
        .inst1_word    (inst1_word),
        .inst2_pc      (inst2_pc),
        .inst2_word    (inst2_word),
        .inst2_valid   (inst2_valid),
        .flush         (flush)
    );

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r[15:0]) % n;
    endfunction

    // small register set so dependencies come up often
    function automatic logic [31:0] gen_inst();
        logic [31:0] r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        r  = $random(seed);
        rs = {3'b000, r[1:0]};
        rt = {3'b000, r[3:2]};
        rd = {3'b000, r[5:4]};
        case (r[12:8])
            5'd0:  return {fetch_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fetch_pkg::FUNC_ADDU};
            5'd1:  return {fetch_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fetch_pkg::FUNC_SUBU};
            5'd2:  return {fetch_pkg::OP_SPECIAL, 5'd0, rt, rd, r[20:16], fetch_pkg::FUNC_SLL};
            5'd3:  return {fetch_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fetch_pkg::FUNC_SLLV};
            5'd4:  return {fetch_pkg::OP_SPECIAL, rs, rt, 10'd0, fetch_pkg::FUNC_MULT};
            5'd5:  return {fetch_pkg::OP_SPECIAL, 5'd0, rt, rd, 5'd0, fetch_pkg::FUNC_MFHI};
            5'd6:  return {fetch_pkg::OP_SPECIAL, 5'd0, rt, rd, 5'd0, fetch_pkg::FUNC_MFLO};
            5'd7:  return {fetch_pkg::OP_SPECIAL, rs, 15'd0, fetch_pkg::FUNC_MTHI};
            5'd8:  return {fetch_pkg::OP_SPECIAL, rs, 15'd0, fetch_pkg::FUNC_JR};
            5'd9:  return {fetch_pkg::OP_SPECIAL, rs, 5'd0, rd, 5'd0, fetch_pkg::FUNC_JALR};
            5'd10: return {fetch_pkg::OP_ADDIU, rs, rt, r[31:16]};
            5'd11: return {fetch_pkg::OP_ORI, rs, rt, r[31:16]};
            5'd12: return {fetch_pkg::OP_LW, rs, rt, r[31:16]};
            5'd13: return {fetch_pkg::OP_LB, rs, rt, r[31:16]};
            5'd14: return {fetch_pkg::OP_LWL, rs, rt, r[31:16]};
            5'd15: return {fetch_pkg::OP_SW, rs, rt, r[31:16]};
            5'd16: return {fetch_pkg::OP_SB, rs, rt, r[31:16]};
            5'd17: return {fetch_pkg::OP_BEQ, rs, rt, r[31:16]};
            5'd18: return {fetch_pkg::OP_BNE, rs, rt, r[31:16]};
            5'd19: return {fetch_pkg::OP_BLEZ, rs, 5'd0, r[31:16]};
            5'd20: return {fetch_pkg::OP_REGIMM, rs, 5'd1, r[31:16]};
            5'd21: return {fetch_pkg::OP_J, 10'd0, r[31:16]};
            5'd22: return {fetch_pkg::OP_JAL, 10'd0, r[31:16]};
            5'd23: return {fetch_pkg::OP_COP0, fetch_pkg::COP0_MF, rt, rd, 11'd0};
            5'd24: return {fetch_pkg::OP_COP0, fetch_pkg::COP0_MT, rt, rd, 11'd0};
            5'd25: return {fetch_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fetch_pkg::FUNC_SLT};
            5'd26: return {fetch_pkg::OP_LHU, rs, rt, r[31:16]};
            default: return {fetch_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fetch_pkg::FUNC_OR};
        endcase
    endfunction

    // load, mfc0, mfhi and mflo
    function automatic logic first_is_load(logic [31:0] w);
        logic [5:0] op;
        logic [5:0] func;
        op   = w[31:26];
        func = w[5:0];
        if (op inside {fetch_pkg::OP_LB, fetch_pkg::OP_LH, fetch_pkg::OP_LW, fetch_pkg::OP_LBU,
                       fetch_pkg::OP_LHU, fetch_pkg::OP_LWL, fetch_pkg::OP_LWR}) begin
            return 1'b1;
        end
        if (op == fetch_pkg::OP_COP0) begin
            return w[25:21] == fetch_pkg::COP0_MF;
        end
        if (op == fetch_pkg::OP_SPECIAL) begin
            return func == fetch_pkg::FUNC_MFHI || func == fetch_pkg::FUNC_MFLO;
        end
        return 1'b0;
    endfunction

    function automatic logic is_branch(logic [31:0] w);
        logic [5:0] op;
        logic [5:0] func;
        op   = w[31:26];
        func = w[5:0];
        if (op == fetch_pkg::OP_SPECIAL) begin
            return func == fetch_pkg::FUNC_JR || func == fetch_pkg::FUNC_JALR;
        end
        return op inside {fetch_pkg::OP_REGIMM, fetch_pkg::OP_J, fetch_pkg::OP_JAL,
                          fetch_pkg::OP_BEQ, fetch_pkg::OP_BNE, fetch_pkg::OP_BLEZ,
                          fetch_pkg::OP_BGTZ};
    endfunction

    // bit 1 reads rs, bit 0 reads rt
    function automatic logic [1:0] source_regs(logic [31:0] w);
        logic [5:0] op;
        logic [5:0] func;
        op   = w[31:26];
        func = w[5:0];
        if (op == fetch_pkg::OP_SPECIAL) begin
            if (func inside {fetch_pkg::FUNC_SLL, fetch_pkg::FUNC_SRL, fetch_pkg::FUNC_SRA}) begin
                return 2'b01;
            end
            if (func inside {fetch_pkg::FUNC_MTHI, fetch_pkg::FUNC_MTLO,
                             fetch_pkg::FUNC_JR, fetch_pkg::FUNC_JALR}) begin
                return 2'b10;
            end
            if (func inside {fetch_pkg::FUNC_MFHI, fetch_pkg::FUNC_MFLO}) begin
                return 2'b00;
            end
            return 2'b11;
        end
        if (op inside {fetch_pkg::OP_BEQ, fetch_pkg::OP_BNE, fetch_pkg::OP_LWL,
                       fetch_pkg::OP_LWR, fetch_pkg::OP_SB, fetch_pkg::OP_SH,
                       fetch_pkg::OP_SW, fetch_pkg::OP_SWL, fetch_pkg::OP_SWR}) begin
            return 2'b11;
        end
        if (op == fetch_pkg::OP_COP0) begin
            return {1'b0, w[25:21] == fetch_pkg::COP0_MT};
        end
        if (op == fetch_pkg::OP_J || op == fetch_pkg::OP_JAL || op == fetch_pkg::OP_LUI) begin
            return 2'b00;
        end
        return 2'b10;
    endfunction

    function automatic logic expect_single(logic [31:0] first, logic [31:0] second);
        logic [1:0] src;
        logic [4:0] dest;
        logic       hit;
        src  = source_regs(second);
        dest = first[20:16];
        hit  = (src[1] && second[25:21] == dest) || (src[0] && second[20:16] == dest);
        return is_branch(second) || (first_is_load(first) && dest != 5'd0 && hit);
    endfunction

    task automatic report_error(string test, logic [31:0] expected, logic [31:0] actual);
        errors++;
        $display("Error %s: expected %h actual %h at %0t", test, expected, actual, $time);
    endtask

    task automatic note_timeout(string what);
        timeouts++;
        $display("timeout: %s did not happen within %0d cycles", what, max_wait);
    endtask

    // one clock: drive, check against the model, then advance the model
    task automatic run_cycle(input logic req, input logic flush_now, input logic ds_ready);
        logic            exp_allow;
        logic            exp_valid;
        logic            single;
        logic            accept;
        logic            reply;
        logic            written;
        logic [xlen-1:0] drop;
        int              n;

        @(negedge clk);
        to_fs_valid = req;
        fetch_pc    = next_fetch_pc;
        flush       = flush_now;
        ds_allowin  = ds_ready;
        reply       = 1'b0;
        n           = 0;
        if (reply_due && reply_delay == 0) begin
            reply     = 1'b1;
            reply_due = 1'b0;
            n         = 1 + rand_below(line_words);
            line_count = cnt_w'(n);
            for (int k = 0; k < line_words; k++) begin
                line_data[k*xlen +: xlen] = gen_inst();
            end
        end else if (reply_due) begin
            reply_delay--;
        end
        line_ok = reply;
        #2;

        exp_allow = ctrl_state == st_wait && model_word.size() <= 7;
        exp_valid = model_word.size() >= 2 && !flush_now;
        single    = 1'b0;

        if (pc_step !== exp_step) report_error("pc_step", 32'(exp_step), 32'(pc_step));
        if (fs_allowin !== exp_allow) report_error("fs_allowin", 32'(exp_allow), 32'(fs_allowin));
        if (fs_to_ds_valid !== exp_valid) begin
            report_error("fs_to_ds_valid", 32'(exp_valid), 32'(fs_to_ds_valid));
        end
        if (exp_valid) begin
            single = expect_single(model_word[0], model_word[1]);
            if (inst1_pc !== model_pc[0]) report_error("inst1_pc", model_pc[0], inst1_pc);
            if (inst1_word !== model_word[0]) report_error("inst1_word", model_word[0], inst1_word);
            if (inst2_pc !== model_pc[1]) report_error("inst2_pc", model_pc[1], inst2_pc);
            if (inst2_valid !== !single) report_error("inst2_valid", 32'(!single), 32'(inst2_valid));
            if (inst2_word !== (single ? 32'd0 : model_word[1])) begin
                report_error("inst2_word", single ? 32'd0 : model_word[1], inst2_word);
            end
            if (held && inst1_pc !== held_pc) report_error("stall inst1_pc", held_pc, inst1_pc);
            if (held && inst2_word !== held_word) begin
                report_error("stall inst2_word", held_word, inst2_word);
            end
        end

        accept  = req && exp_allow;
        written = reply && ctrl_state == st_recv && !flush_now;
        held    = exp_valid && !ds_ready;
        if (held) begin
            held_pc   = model_pc[0];
            held_word = single ? 32'd0 : model_word[1];
        end

        if (flush_now) begin
            model_word.delete();
            model_pc.delete();
            exp_step = step_w'(4);
            flushes++;
        end else if (exp_valid && ds_ready) begin
            pairs++;
            drop = model_word.pop_front();
            drop = model_pc.pop_front();
            if (single) begin
                singles++;
            end else begin
                drop = model_word.pop_front();
                drop = model_pc.pop_front();
            end
        end
        if (written) begin
            for (int k = 0; k < n; k++) begin
                model_word.push_back(line_data[k*xlen +: xlen]);
                model_pc.push_back(req_pc + 32'(4 * k));
            end
            exp_step = step_w'(4 * n);
            next_fetch_pc = req_pc + 32'(4 * n);
            lines++;
        end

        case (ctrl_state)
            st_wait: begin
                if (accept) begin
                    req_pc      = fetch_pc;
                    reply_due   = 1'b1;
                    reply_delay = rand_below(5);
                    ctrl_state  = flush_now ? st_discard : st_recv;
                end
            end
            st_recv: begin
                if (reply) ctrl_state = st_wait;
                else if (flush_now) ctrl_state = st_discard;
            end
            st_discard: begin
                if (reply) ctrl_state = st_wait;
            end
            default: ctrl_state = st_wait;
        endcase

        // redirect target after a flush
        if (flush_now) next_fetch_pc = {next_fetch_pc[31:16] ^ 16'(rand_below(4096)), 16'h0000};
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        @(posedge clk);
        while (reset && n < max_wait) begin
            @(posedge clk);
            n++;
        end
        if (reset) note_timeout("reset release");
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        #2;
        if (fs_to_ds_valid !== 1'b0) report_error("reset valid", 32'd0, 32'(fs_to_ds_valid));
        if (fs_allowin !== 1'b1) report_error("reset allowin", 32'd1, 32'(fs_allowin));
        if (pc_step !== step_w'(4)) report_error("reset pc_step", 32'd4, 32'(pc_step));
    endtask

    task automatic random_phase(int cycles);
        int ds_pct;
        for (int c = 0; c < cycles; c++) begin
            // alternate heavy and light decode stalls
            ds_pct = ((c / 250) % 2 == 0) ? 40 : 90;
            run_cycle(rand_below(4) != 0, rand_below(50) == 0, rand_below(100) < ds_pct);
        end
    endtask

    task automatic flush_while_outstanding();
        int n;
        n = 0;
        while ((ctrl_state != st_wait || reply_due) && n < max_wait) begin
            run_cycle(1'b0, 1'b0, 1'b1);
            n++;
        end
        if (ctrl_state != st_wait || reply_due) note_timeout("idle controller");
        n = 0;
        while (ctrl_state != st_recv && n < max_wait) begin
            run_cycle(1'b1, 1'b0, 1'b1);
            n++;
        end
        if (ctrl_state != st_recv) begin
            note_timeout("request acceptance");
        end else begin
            // hold the reply back so the flush lands first
            reply_delay = 4;
            run_cycle(1'b0, 1'b1, 1'b1);
            n = 0;
            while (ctrl_state != st_wait && n < max_wait) begin
                run_cycle(1'b0, 1'b0, 1'b1);
                n++;
            end
            if (ctrl_state != st_wait) note_timeout("discarded reply");
            run_cycle(1'b0, 1'b0, 1'b1);
        end
    endtask

    task automatic drain_queue();
        int n;
        n = 0;
        while ((model_word.size() >= 2 || ctrl_state != st_wait || reply_due) && n < max_wait) begin
            run_cycle(1'b0, 1'b0, 1'b1);
            n++;
        end
        if (model_word.size() >= 2 || ctrl_state != st_wait || reply_due) begin
            note_timeout("queue drain");
        end
    endtask

    initial begin
        to_fs_valid = 1'b0;
        fetch_pc    = '0;
        line_ok     = 1'b0;
        line_count  = '0;
        line_data   = '0;
        ds_allowin  = 1'b0;
        flush       = 1'b0;

        wait_reset_release();
        if (timeouts == 0) check_reset_state();
        if (timeouts == 0) random_phase(3000);
        if (timeouts == 0) flush_while_outstanding();
        if (timeouts == 0) random_phase(500);
        if (timeouts == 0) drain_queue();

        $display("%0d pairs, %0d single, %0d lines, %0d flushes, %0d errors, %0d timeouts",
                 pairs, singles, lines, flushes, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (20000) @(posedge clk);
        $display("simulation ran past its cycle limit");
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int period       = 20,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // released on a falling edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage #(
    parameter int line_words  = fetch_pkg::LINE_WORDS_DEFAULT,
    parameter int queue_depth = fetch_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  logic                                  clk,
    input  logic                                  reset,

    input  logic                                  to_fs_valid,
    input  logic [fetch_pkg::XLEN-1:0]            fetch_pc,
    output logic                                  fs_allowin,
    output logic [$clog2(line_words + 1) + 1:0]   pc_step,

    input  logic                                  line_ok,
    input  logic [$clog2(line_words + 1) - 1:0]   line_count,
    input  logic [line_words*fetch_pkg::XLEN-1:0] line_data,

    input  logic                                  ds_allowin,
    output logic                                  fs_to_ds_valid,
    output logic [fetch_pkg::XLEN-1:0]            inst1_pc,
    output logic [fetch_pkg::XLEN-1:0]            inst1_word,
    output logic [fetch_pkg::XLEN-1:0]            inst2_pc,
    output logic [fetch_pkg::XLEN-1:0]            inst2_word,
    output logic                                  inst2_valid,

    input  logic                                  flush
);

    logic                       line_write;
    logic [fetch_pkg::XLEN-1:0] line_pc;
    logic                       queue_has_room;
    logic                       pair_ready;
    logic [fetch_pkg::XLEN-1:0] head_word;
    logic [fetch_pkg::XLEN-1:0] head_pc;
    logic [fetch_pkg::XLEN-1:0] next_word;
    logic [fetch_pkg::XLEN-1:0] next_pc;
    logic                       single_issue;
    logic                       pop;
    logic                       pop_two;

    fetch_ctrl #(
        .line_words(line_words)
    ) u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .to_fs_valid   (to_fs_valid),
        .fetch_pc      (fetch_pc),
        .line_ok       (line_ok),
        .line_count    (line_count),
        .flush         (flush),
        .queue_has_room(queue_has_room),
        .fs_allowin    (fs_allowin),
        .pc_step       (pc_step),
        .line_write    (line_write),
        .line_pc       (line_pc)
    );

    inst_queue #(
        .line_words (line_words),
        .queue_depth(queue_depth)
    ) u_queue (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .line_write    (line_write),
        .line_count    (line_count),
        .line_data     (line_data),
        .line_pc       (line_pc),
        .pop           (pop),
        .pop_two       (pop_two),
        .queue_has_room(queue_has_room),
        .pair_ready    (pair_ready),
        .head_word     (head_word),
        .head_pc       (head_pc),
        .next_word     (next_word),
        .next_pc       (next_pc)
    );

    pair_classify u_classify (
        .head_word   (head_word),
        .next_word   (next_word),
        .single_issue(single_issue)
    );

    // a pair is offered only with two entries queued
    assign fs_to_ds_valid = pair_ready & ~flush;
    assign pop            = fs_to_ds_valid & ds_allowin;
    assign pop_two        = ~single_issue;

    assign inst1_pc    = head_pc;
    assign inst1_word  = head_word;
    assign inst2_pc    = next_pc;
    assign inst2_valid = ~single_issue;
    // withdrawn second slot reads as a nop
    assign inst2_word  = inst2_valid ? next_word : '0;

endmodule

//--- hw/fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl #(
    parameter int line_words = 8
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                to_fs_valid,
    input  logic [fetch_pkg::XLEN-1:0]          fetch_pc,
    input  logic                                line_ok,
    input  logic [$clog2(line_words + 1) - 1:0] line_count,
    input  logic                                flush,
    input  logic                                queue_has_room,
    output logic                                fs_allowin,
    output logic [$clog2(line_words + 1) + 1:0] pc_step,
    output logic                                line_write,
    output logic [fetch_pkg::XLEN-1:0]          line_pc
);

    localparam logic [1:0] s_wait    = 2'd0;
    localparam logic [1:0] s_recv    = 2'd1;
    localparam logic [1:0] s_discard = 2'd2;

    logic [1:0] state;
    logic       accept;

    assign fs_allowin = (state == s_wait) & queue_has_room;
    assign accept     = to_fs_valid & fs_allowin;
    assign line_write = (state == s_recv) & line_ok & ~flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_wait;
        end else begin
            case (state)
                s_wait: begin
                    if (accept && flush) begin
                        state <= s_discard;
                    end else if (accept) begin
                        state <= s_recv;
                    end
                end
                s_recv: begin
                    // a reply arriving with flush is simply dropped
                    if (line_ok) begin
                        state <= s_wait;
                    end else if (flush) begin
                        state <= s_discard;
                    end
                end
                s_discard: begin
                    if (line_ok) begin
                        state <= s_wait;
                    end
                end
                default: begin
                    state <= s_wait;
                end
            endcase
        end
    end

    // pc of the outstanding request
    always_ff @(posedge clk) begin
        if (accept) begin
            line_pc <= fetch_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            pc_step <= 'd4;
        end else if (line_write) begin
            pc_step <= {line_count, 2'b00};
        end
    end

endmodule

//--- hw/inst_queue.sv
`timescale 1ns/1ns

module inst_queue #(
    parameter int line_words  = 8,
    parameter int queue_depth = 16
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  flush,

    input  logic                                  line_write,
    input  logic [$clog2(line_words + 1) - 1:0]   line_count,
    input  logic [line_words*fetch_pkg::XLEN-1:0] line_data,
    input  logic [fetch_pkg::XLEN-1:0]            line_pc,

    input  logic                                  pop,
    input  logic                                  pop_two,

    output logic                                  queue_has_room,
    output logic                                  pair_ready,
    output logic [fetch_pkg::XLEN-1:0]            head_word,
    output logic [fetch_pkg::XLEN-1:0]            head_pc,
    output logic [fetch_pkg::XLEN-1:0]            next_word,
    output logic [fetch_pkg::XLEN-1:0]            next_pc
);

    localparam int idx_w = $clog2(queue_depth);
    localparam int cnt_w = $clog2(line_words + 1);
    // extra bit tells full from empty
    localparam int ptr_w = idx_w + 1;

    logic [fetch_pkg::XLEN-1:0] word_mem [queue_depth];
    logic [fetch_pkg::XLEN-1:0] pc_mem   [queue_depth];

    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [ptr_w-1:0] count;
    logic [idx_w-1:0] head_idx;
    logic [idx_w-1:0] next_idx;
    logic [idx_w-1:0] tail_idx;

    assign head_idx = head[idx_w-1:0];
    assign next_idx = head_idx + 1'b1;
    assign tail_idx = tail[idx_w-1:0];

    assign count = tail - head;

    // a full line must still fit behind what is queued
    assign queue_has_room = count < ptr_w'(queue_depth - line_words);
    assign pair_ready     = count >= ptr_w'(2);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            tail <= '0;
        end else if (line_write) begin
            tail <= tail + ptr_w'(line_count);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head <= '0;
        end else if (pop) begin
            head <= head + (pop_two ? ptr_w'(2) : ptr_w'(1));
        end
    end

    // word k lands at tail + k, its pc four bytes past word k-1
    always_ff @(posedge clk) begin
        if (line_write) begin
            for (int k = 0; k < line_words; k++) begin
                if (line_count > k[cnt_w-1:0]) begin
                    word_mem[tail_idx + k[idx_w-1:0]] <=
                        line_data[k*fetch_pkg::XLEN +: fetch_pkg::XLEN];
                    pc_mem[tail_idx + k[idx_w-1:0]] <= line_pc + 4 * k;
                end
            end
        end
    end

    assign head_word = word_mem[head_idx];
    assign head_pc   = pc_mem[head_idx];
    assign next_word = word_mem[next_idx];
    assign next_pc   = pc_mem[next_idx];

endmodule

//--- hw/pair_classify.sv
`timescale 1ns/1ns

module pair_classify (
    input  fetch_pkg::inst_word_t head_word,
    input  fetch_pkg::inst_word_t next_word,
    output logic                  single_issue
);

    logic first_load;
    logic second_branch;
    logic reads_rs;
    logic reads_rt;
    logic rs_hit;
    logic rt_hit;

    // first slot writes rt from memory, cop0 or hi/lo
    always_comb begin
        case (head_word.i.op)
            fetch_pkg::OP_LB, fetch_pkg::OP_LH, fetch_pkg::OP_LW,
            fetch_pkg::OP_LBU, fetch_pkg::OP_LHU,
            fetch_pkg::OP_LWL, fetch_pkg::OP_LWR: first_load = 1'b1;
            fetch_pkg::OP_COP0: first_load = head_word.i.rs == fetch_pkg::COP0_MF;
            fetch_pkg::OP_SPECIAL: first_load = head_word.r.func == fetch_pkg::FUNC_MFHI ||
                                                head_word.r.func == fetch_pkg::FUNC_MFLO;
            default: first_load = 1'b0;
        endcase
    end

    always_comb begin
        case (next_word.i.op)
            fetch_pkg::OP_REGIMM, fetch_pkg::OP_J, fetch_pkg::OP_JAL,
            fetch_pkg::OP_BEQ, fetch_pkg::OP_BNE,
            fetch_pkg::OP_BLEZ, fetch_pkg::OP_BGTZ: second_branch = 1'b1;
            fetch_pkg::OP_SPECIAL: second_branch = next_word.r.func == fetch_pkg::FUNC_JR ||
                                                   next_word.r.func == fetch_pkg::FUNC_JALR;
            default: second_branch = 1'b0;
        endcase
    end

    // source registers read by the second slot
    always_comb begin
        reads_rs = 1'b0;
        reads_rt = 1'b0;
        case (next_word.i.op)
            fetch_pkg::OP_SPECIAL: begin
                case (next_word.r.func)
                    fetch_pkg::FUNC_ADD, fetch_pkg::FUNC_ADDU, fetch_pkg::FUNC_SUB,
                    fetch_pkg::FUNC_SUBU, fetch_pkg::FUNC_AND, fetch_pkg::FUNC_OR,
                    fetch_pkg::FUNC_XOR, fetch_pkg::FUNC_NOR, fetch_pkg::FUNC_SLT,
                    fetch_pkg::FUNC_SLTU, fetch_pkg::FUNC_SLLV, fetch_pkg::FUNC_SRLV,
                    fetch_pkg::FUNC_SRAV, fetch_pkg::FUNC_MULT, fetch_pkg::FUNC_MULTU,
                    fetch_pkg::FUNC_DIV, fetch_pkg::FUNC_DIVU: begin
                        reads_rs = 1'b1;
                        reads_rt = 1'b1;
                    end
                    fetch_pkg::FUNC_SLL, fetch_pkg::FUNC_SRL, fetch_pkg::FUNC_SRA: begin
                        reads_rt = 1'b1;
                    end
                    fetch_pkg::FUNC_MTHI, fetch_pkg::FUNC_MTLO,
                    fetch_pkg::FUNC_JR, fetch_pkg::FUNC_JALR: begin
                        reads_rs = 1'b1;
                    end
                    default: ;
                endcase
            end
            fetch_pkg::OP_BEQ, fetch_pkg::OP_BNE, fetch_pkg::OP_LWL, fetch_pkg::OP_LWR,
            fetch_pkg::OP_SB, fetch_pkg::OP_SH, fetch_pkg::OP_SW,
            fetch_pkg::OP_SWL, fetch_pkg::OP_SWR: begin
                reads_rs = 1'b1;
                reads_rt = 1'b1;
            end
            fetch_pkg::OP_REGIMM, fetch_pkg::OP_BLEZ, fetch_pkg::OP_BGTZ,
            fetch_pkg::OP_ADDI, fetch_pkg::OP_ADDIU, fetch_pkg::OP_SLTI,
            fetch_pkg::OP_SLTIU, fetch_pkg::OP_ANDI, fetch_pkg::OP_ORI,
            fetch_pkg::OP_XORI, fetch_pkg::OP_LB, fetch_pkg::OP_LH,
            fetch_pkg::OP_LW, fetch_pkg::OP_LBU, fetch_pkg::OP_LHU: begin
                reads_rs = 1'b1;
            end
            fetch_pkg::OP_COP0: begin
                reads_rt = next_word.i.rs == fetch_pkg::COP0_MT;
            end
            default: ;
        endcase
    end

    // r0 never carries a dependency
    assign rs_hit = reads_rs && next_word.i.rs == head_word.i.rt;
    assign rt_hit = reads_rt && next_word.i.rt == head_word.i.rt;

    assign single_issue = second_branch ||
                          (first_load && head_word.i.rt != '0 && (rs_hit || rt_hit));

endmodule

//--- hw/fetch_pkg.sv
package fetch_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // words per cache line and queue entries
    localparam int LINE_WORDS_DEFAULT  = 8;
    localparam int QUEUE_DEPTH_DEFAULT = 16;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_COP0    = 6'h10;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LH      = 6'h21;
    localparam logic [5:0] OP_LWL     = 6'h22;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_LHU     = 6'h25;
    localparam logic [5:0] OP_LWR     = 6'h26;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SH      = 6'h29;
    localparam logic [5:0] OP_SWL     = 6'h2a;
    localparam logic [5:0] OP_SW      = 6'h2b;
    localparam logic [5:0] OP_SWR     = 6'h2e;

    // cop0 move selects, held in the rs field
    localparam logic [4:0] COP0_MF = 5'h00;
    localparam logic [4:0] COP0_MT = 5'h04;

    // special function codes
    localparam logic [5:0] FUNC_SLL   = 6'h00;
    localparam logic [5:0] FUNC_SRL   = 6'h02;
    localparam logic [5:0] FUNC_SRA   = 6'h03;
    localparam logic [5:0] FUNC_SLLV  = 6'h04;
    localparam logic [5:0] FUNC_SRLV  = 6'h06;
    localparam logic [5:0] FUNC_SRAV  = 6'h07;
    localparam logic [5:0] FUNC_JR    = 6'h08;
    localparam logic [5:0] FUNC_JALR  = 6'h09;
    localparam logic [5:0] FUNC_MFHI  = 6'h10;
    localparam logic [5:0] FUNC_MTHI  = 6'h11;
    localparam logic [5:0] FUNC_MFLO  = 6'h12;
    localparam logic [5:0] FUNC_MTLO  = 6'h13;
    localparam logic [5:0] FUNC_MULT  = 6'h18;
    localparam logic [5:0] FUNC_MULTU = 6'h19;
    localparam logic [5:0] FUNC_DIV   = 6'h1a;
    localparam logic [5:0] FUNC_DIVU  = 6'h1b;
    localparam logic [5:0] FUNC_ADD   = 6'h20;
    localparam logic [5:0] FUNC_ADDU  = 6'h21;
    localparam logic [5:0] FUNC_SUB   = 6'h22;
    localparam logic [5:0] FUNC_SUBU  = 6'h23;
    localparam logic [5:0] FUNC_AND   = 6'h24;
    localparam logic [5:0] FUNC_OR    = 6'h25;
    localparam logic [5:0] FUNC_XOR   = 6'h26;
    localparam logic [5:0] FUNC_NOR   = 6'h27;
    localparam logic [5:0] FUNC_SLT   = 6'h2a;
    localparam logic [5:0] FUNC_SLTU  = 6'h2b;

    // one instruction word, register layout or immediate layout
    typedef union packed {
        struct packed {
            logic [5:0]            op;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [REG_ADDR_W-1:0] rd;
            logic [4:0]            sa;
            logic [5:0]            func;
        } r;
        struct packed {
            logic [5:0]            op;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [15:0]           imm;
        } i;
    } inst_word_t;

endpackage
